//--- sources.f
+incdir+include
src/fdDataPkg.sv
src/fdCtrlPkg.sv
src/freqExtIfs.sv
src/hashTable.sv
src/hashCounter.sv
src/resultWriter.sv
src/runMonitor.sv
src/freqExtTop.sv
dv/freqExtTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; a failing run exits nonzero
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	-f sources.f \
	--top-module freqExtTb \
	--Mdir build \
	-o freqExtSim

./build/freqExtSim

//--- dv/freqExtTb.sv
// Expects the fixed 16-slot table and numBlock of 3; resReady back-pressure comes from a fixed seed
`include "freqExt_consts.svh"

module freqExtTb import fdDataPkg::*, fdCtrlPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int numRows = 17;
	localparam int numBlocks = 3;
	localparam int timeoutCycles = 8 * (numRows + 17 * numBlocks) + 100;

	// Rows are {last, word}; block 0 has two collisions on slot 1
	localparam logic [16:0] stim [numRows] = '{
		17'h0_0011, 17'h0_0011, 17'h0_0023, 17'h0_0011,
		17'h0_0121, 17'h0_0023, 17'h0_0531, 17'h1_00af,
		17'h0_0011, 17'h0_1233, 17'h0_0043, 17'h1_1233,
		// Word 0 claims slot 0 with key 0, then 0010 collides there
		17'h0_ffff, 17'h0_fffe, 17'h0_ffff, 17'h0_0000, 17'h1_0010
	};
	localparam fdCount expColl [numBlocks] = '{16'd2, 16'd1, 16'd1};

	logic clk;
	logic rst;
	logic enable;
	logic [`NUM_BLOCK_W-1:0] numBlock;
	logic wordValid;
	logic wordLast;
	fdWord wordData;
	logic wordReady;
	logic resValid;
	logic resReady;
	fdResultKind resKind;
	fdResult resData;
	logic [`ADDR_W-1:0] resAddr;
	logic complete;
	logic [`TIMER_W-1:0] timer;

	fdEntry expTable [numBlocks][`HASH_LEN];
	fdCollision expCollision;
	logic counting = 1'b0;
	int cycles = 0;
	int runCycles = 0;
	int finalCycles = 0;
	int blockSeen = 0;
	int slotSeen = 0;

	freqExtTop i_freqExtTop (.*);

	always #5 clk = ~clk;

	////////////////////////////////////////
	// Failure and compare helpers
	task automatic abortRun(string reason);
		$display("%s", reason);
		$display("Test failures found");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic checkEntry(string name, fdEntry exp, fdEntry act,
		logic [`ADDR_W-1:0] expAddr, logic [`ADDR_W-1:0] actAddr);
		if (act !== exp || actAddr !== expAddr)
		begin
			abortRun($sformatf(
				"[FAIL] %s expected key %h count %0d addr %0d, actual key %h count %0d addr %0d",
				name, exp.key, exp.count, expAddr, act.key, act.count, actAddr));
		end
	endtask

	task automatic checkCollision(string name, fdCollision exp, fdCollision act,
		logic [`ADDR_W-1:0] expAddr, logic [`ADDR_W-1:0] actAddr);
		if (act !== exp || actAddr !== expAddr)
		begin
			abortRun($sformatf("[FAIL] %s expected word %h addr %0d, actual word %h addr %0d",
				name, exp, expAddr, act, actAddr));
		end
	endtask

	task automatic checkFlag(string name, logic exp, logic act);
		if (act !== exp)
		begin
			abortRun($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
		end
	endtask

	task automatic checkTimer(string name, logic [`TIMER_W-1:0] exp, logic [`TIMER_W-1:0] act);
		if (act !== exp)
		begin
			abortRun($sformatf("[FAIL] %s expected %0d actual %0d", name, exp, act));
		end
	endtask

	// Reference model: first key claims a slot, same key counts, other keys are dropped
	task automatic buildModel();
		fdEntry slots [`HASH_LEN];
		fdWord w;
		fdIndex idx;
		int blk;
		slots = '{default: '0};
		blk = 0;
		for (int r = 0; r < numRows; r++)
		begin
			w = stim[r][15:0];
			idx = w[`HASH_BITS-1:0];
			if (slots[idx].count == '0)
			begin
				slots[idx].key = w;
				slots[idx].count = fdCount'(1);
			end
			else if (slots[idx].key == w)
			begin
				slots[idx].count = slots[idx].count + fdCount'(1);
			end
			if (stim[r][16])
			begin
				for (int s = 0; s < `HASH_LEN; s++)
				begin
					expTable[blk][s] = slots[s];
					slots[s] = '0;
				end
				blk++;
			end
		end
	endtask

	////////////////////////////////////////
	// Back-pressure, timeout and result checks
	initial
	begin
		void'($urandom(32'hc6b7));
		forever
		begin
			@(posedge clk);
			#1;
			resReady = 1'($urandom % 2);
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (counting)
		begin
			runCycles++;
		end
		if (cycles >= timeoutCycles)
		begin
			abortRun($sformatf("Timeout: run did not finish within %0d cycles", timeoutCycles));
		end
	end

	// Transfer happens on the next rising edge
	always @(negedge clk)
	begin
		if (!rst && resValid && resReady)
		begin
			if (blockSeen >= numBlocks)
			begin
				abortRun("A result was sent after the last block");
			end
			if (resKind == kindEntry)
			begin
				if (slotSeen >= `HASH_LEN)
				begin
					abortRun($sformatf("Block %0d sent more than 16 entries", blockSeen));
				end
				checkEntry($sformatf("block %0d slot %0d", blockSeen, slotSeen),
					expTable[blockSeen][slotSeen], resData.entry,
					`ADDR_W'((blockSeen * `HASH_LEN + slotSeen) * `ADDR_STEP), resAddr);
				slotSeen++;
			end
			else
			begin
				if (slotSeen != `HASH_LEN)
				begin
					abortRun($sformatf("Block %0d sent its collision word after %0d entries",
						blockSeen, slotSeen));
				end
				expCollision.pad = '0;
				expCollision.count = expColl[blockSeen];
				checkCollision($sformatf("block %0d collisions", blockSeen), expCollision,
					resData.collision, `ADDR_W'(blockSeen * `ADDR_STEP), resAddr);
				if (blockSeen == numBlocks - 1)
				begin
					finalCycles = runCycles + 1;
				end
				blockSeen++;
				slotSeen = 0;
			end
		end
	end

	////////////////////////////////////////
	// Main sequence
	initial
	begin
		logic taken;
		logic [`TIMER_W-1:0] heldTimer;
		clk = 1'b0;
		rst = 1'b1;
		enable = 1'b0;
		numBlock = `NUM_BLOCK_W'(numBlocks);
		wordValid = 1'b0;
		wordLast = 1'b0;
		wordData = '0;
		resReady = 1'b0;
		buildModel();
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;

		// Idle before enable
		@(negedge clk);
		checkFlag("wordReady before enable", 1'b0, wordReady);
		checkFlag("resValid before enable", 1'b0, resValid);
		checkFlag("complete before enable", 1'b0, complete);
		checkTimer("timer before enable", '0, timer);

		@(posedge clk);
		#1;
		enable = 1'b1;
		counting = 1'b1;
		@(posedge clk);
		#1;
		enable = 1'b0;

		for (int r = 0; r < numRows; r++)
		begin
			wordValid = 1'b1;
			wordData = stim[r][15:0];
			wordLast = stim[r][16];
			do
			begin
				@(negedge clk);
				taken = wordReady;
				@(posedge clk);
				#1;
			end
			while (!taken);
		end
		wordValid = 1'b0;
		wordLast = 1'b0;

		wait (complete);
		@(negedge clk);
		heldTimer = timer;
		if (heldTimer == '0 || heldTimer < `TIMER_W'(finalCycles))
		begin
			abortRun($sformatf("[FAIL] run timer expected at least %0d, actual %0d",
				finalCycles, heldTimer));
		end

		// Offer one more word after completion
		@(posedge clk);
		#1;
		wordValid = 1'b1;
		wordData = 16'h0055;
		repeat (20)
		begin
			@(negedge clk);
			checkFlag("wordReady after complete", 1'b0, wordReady);
			checkFlag("complete held", 1'b1, complete);
			checkFlag("resValid after complete", 1'b0, resValid);
			checkTimer("timer held", heldTimer, timer);
		end

		if (blockSeen == numBlocks && slotSeen == 0)
		begin
			$display("All tests passed!");
			$finish;
		end
		else
		begin
			abortRun($sformatf("Run ended with %0d blocks and %0d stray entries dumped",
				blockSeen, slotSeen));
		end
	end

endmodule

//--- src/freqExtTop.sv
// Single-lane frequency extractor; one word per cycle in, 17 results per block out
`include "freqExt_consts.svh"

module freqExtTop import fdDataPkg::*, fdCtrlPkg::*;
(
	input logic clk,
	input logic rst,
	input logic enable,
	input logic [`NUM_BLOCK_W-1:0] numBlock,
	input logic wordValid,
	input logic wordLast,
	input fdWord wordData,
	output logic wordReady,
	output logic resValid,
	input logic resReady,
	output fdResultKind resKind,
	output fdResult resData,
	output logic [`ADDR_W-1:0] resAddr,
	output logic complete,
	output logic [`TIMER_W-1:0] timer
);

	wordStreamIf wordIf ();
	resultStreamIf resultIf ();

	fdIndex lookupIndex;
	fdEntry lookupEntry;
	fdEntry updateEntry;
	logic update;
	logic clear;
	logic running;
	logic blockDone;

	////////////////////////////////////////
	// Word input
	assign wordIf.valid = wordValid;
	assign wordIf.word = wordData;
	assign wordIf.last = wordLast;
	assign wordReady = wordIf.ready;

	////////////////////////////////////////
	// Core
	hashCounter i_hashCounter
	(
		.clk(clk),
		.rst(rst),
		.words(wordIf.sink),
		.results(resultIf.source),
		.running(running),
		.lookupIndex(lookupIndex),
		.lookupEntry(lookupEntry),
		.update(update),
		.updateEntry(updateEntry),
		.clear(clear),
		.blockDone(blockDone)
	);

	hashTable i_hashTable
	(
		.clk(clk),
		.rst(rst),
		.lookupIndex(lookupIndex),
		.lookupEntry(lookupEntry),
		.update(update),
		.updateEntry(updateEntry),
		.clear(clear)
	);

	resultWriter i_resultWriter
	(
		.clk(clk),
		.rst(rst),
		.upstream(resultIf.sink),
		.resValid(resValid),
		.resReady(resReady),
		.resKind(resKind),
		.resData(resData),
		.resAddr(resAddr)
	);

	runMonitor i_runMonitor
	(
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.numBlock(numBlock),
		.blockDone(blockDone),
		.running(running),
		.complete(complete),
		.timer(timer)
	);

endmodule

//--- src/runMonitor.sv
// numBlock must be at least 1 and stable during a run; complete holds until reset
`include "freqExt_consts.svh"

module runMonitor
(
	input logic clk,
	input logic rst,
	input logic enable,
	input logic [`NUM_BLOCK_W-1:0] numBlock,
	input logic blockDone,
	output logic running,
	output logic complete,
	output logic [`TIMER_W-1:0] timer
);

	logic started;
	logic [`NUM_BLOCK_W-1:0] blockCount;

	assign running = started && !complete;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			started <= 1'b0;
			blockCount <= '0;
			complete <= 1'b0;
			timer <= '0;
		end
		else
		begin
			// Enable is only a pulse so the start is latched
			if (enable)
			begin
				started <= 1'b1;
			end
			if (blockDone)
			begin
				blockCount <= blockCount + 1'b1;
			end
			if (started && (blockCount >= numBlock))
			begin
				complete <= 1'b1;
			end
			if (running)
			begin
				timer <= timer + 1'b1;
			end
		end
	end

endmodule

//--- src/resultWriter.sv
// Entry and collision addresses count up from 0 in separate regions and never wrap back
`include "freqExt_consts.svh"

module resultWriter import fdDataPkg::*, fdCtrlPkg::*;
(
	input logic clk,
	input logic rst,
	resultStreamIf.sink upstream,
	output logic resValid,
	input logic resReady,
	output fdResultKind resKind,
	output fdResult resData,
	output logic [`ADDR_W-1:0] resAddr
);

	logic [`ADDR_W-1:0] entryAddr;
	logic [`ADDR_W-1:0] collisionAddr;
	logic taken;

	assign resValid = upstream.valid;
	assign resKind = upstream.kind;
	assign resData = upstream.data;
	assign upstream.ready = resReady;

	assign taken = upstream.valid && resReady;

	// Region picked by the kind of the word on the port
	assign resAddr = (upstream.kind == kindEntry) ? entryAddr : collisionAddr;

	////////////////////////////////////////
	// Address counters
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			entryAddr <= '0;
			collisionAddr <= '0;
		end
		else if (taken)
		begin
			if (upstream.kind == kindEntry)
			begin
				entryAddr <= entryAddr + `ADDR_W'(`ADDR_STEP);
			end
			else
			begin
				collisionAddr <= collisionAddr + `ADDR_W'(`ADDR_STEP);
			end
		end
	end

endmodule

//--- src/hashCounter.sv
// Accepts words only while running; the dump stalls on back-pressure and blocks input meanwhile
`include "freqExt_consts.svh"

module hashCounter import fdDataPkg::*, fdCtrlPkg::*;
(
	input logic clk,
	input logic rst,
	wordStreamIf.sink words,
	resultStreamIf.source results,
	input logic running,
	output fdIndex lookupIndex,
	input fdEntry lookupEntry,
	output logic update,
	output fdEntry updateEntry,
	output logic clear,
	output logic blockDone
);

	fdCounterState state;
	fdIndex slotIdx;
	fdCount collisionCount;
	fdResult resultWord;
	logic accept;
	logic isEmpty;
	logic isMatch;
	logic resultTaken;

	////////////////////////////////////////
	// Accept side
	assign words.ready = running && (state == sAccept);
	assign accept = words.valid && words.ready;

	// Low bits of the word are the hash
	assign lookupIndex = (state == sAccept) ? words.word[`HASH_BITS-1:0] : slotIdx;
	assign isEmpty = (lookupEntry.count == '0);
	assign isMatch = (lookupEntry.key == words.word);

	assign update = accept && (isEmpty || isMatch);
	assign updateEntry.key = words.word;
	assign updateEntry.count = lookupEntry.count + 1'b1;

	////////////////////////////////////////
	// Dump side
	assign resultTaken = results.valid && results.ready;
	assign clear = resultTaken && (state == sDumpEntries);

	always_comb
	begin
		resultWord = '0;
		if (state == sDumpEntries)
		begin
			resultWord.entry = lookupEntry;
		end
		else
		begin
			resultWord.collision.count = collisionCount;
		end
	end

	assign results.valid = (state != sAccept);
	assign results.kind = (state == sDumpCollision) ? kindCollision : kindEntry;
	assign results.data = resultWord;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= sAccept;
			slotIdx <= '0;
			collisionCount <= '0;
			blockDone <= 1'b0;
		end
		else
		begin
			blockDone <= 1'b0;
			case (state)
				sAccept:
				begin
					if (accept && !isEmpty && !isMatch)
					begin
						collisionCount <= collisionCount + 1'b1;
					end
					if (accept && words.last)
					begin
						state <= sDumpEntries;
						slotIdx <= '0;
					end
				end
				sDumpEntries:
				begin
					if (resultTaken)
					begin
						if (slotIdx == fdIndex'(`HASH_LEN - 1))
						begin
							state <= sDumpCollision;
						end
						slotIdx <= slotIdx + 1'b1;
					end
				end
				sDumpCollision:
				begin
					if (resultTaken)
					begin
						collisionCount <= '0;
						blockDone <= 1'b1;
						state <= sAccept;
					end
				end
				default:
				begin
					state <= sAccept;
				end
			endcase
		end
	end

endmodule

//--- src/hashTable.sv
// Register table of HASH_LEN slots; combinational read, and update wins over clear on one slot
`include "freqExt_consts.svh"

module hashTable import fdDataPkg::*;
(
	input logic clk,
	input logic rst,
	input fdIndex lookupIndex,
	output fdEntry lookupEntry,
	input logic update,
	input fdEntry updateEntry,
	input logic clear
);

	fdEntry slots [`HASH_LEN];

	assign lookupEntry = slots[lookupIndex];

	////////////////////////////////////////
	// Slot writes
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < `HASH_LEN; i++)
			begin
				slots[i] <= '0;
			end
		end
		else if (update)
		begin
			slots[lookupIndex] <= updateEntry;
		end
		else if (clear)
		begin
			// Count 0 marks the slot empty again
			slots[lookupIndex] <= '0;
		end
	end

endmodule

//--- src/freqExtIfs.sv
// Valid/ready streams; a transfer needs both high and the source holds its data until then
interface wordStreamIf import fdDataPkg::*; ();

	logic valid;
	logic ready;
	fdWord word;
	logic last;

	modport source
	(
		output valid,
		output word,
		output last,
		input ready
	);

	modport sink
	(
		input valid,
		input word,
		input last,
		output ready
	);

endinterface

interface resultStreamIf import fdDataPkg::*, fdCtrlPkg::*; ();

	logic valid;
	logic ready;
	fdResultKind kind;
	fdResult data;

	modport source
	(
		output valid,
		output kind,
		output data,
		input ready
	);

	modport sink
	(
		input valid,
		input kind,
		input data,
		output ready
	);

endinterface

//--- src/fdCtrlPkg.sv
// Control encodings only; the dump always runs entries first and then one collision word
package fdCtrlPkg;

	typedef enum logic [1:0]
	{
		sAccept,
		sDumpEntries,
		sDumpCollision
	} fdCounterState;

	// Selects the view of fdResult and the address region
	typedef enum logic
	{
		kindEntry,
		kindCollision
	} fdResultKind;

endpackage

//--- src/fdDataPkg.sv
// Payload types; an entry and a collision word share one RESULT_W-bit result word
`include "freqExt_consts.svh"

package fdDataPkg;

	typedef logic [`WORD_W-1:0] fdWord;
	typedef logic [`COUNT_W-1:0] fdCount;
	typedef logic [`HASH_BITS-1:0] fdIndex;

	// One table slot, key in the upper half
	typedef struct packed
	{
		fdWord key;
		fdCount count;
	} fdEntry;

	typedef struct packed
	{
		logic [`RESULT_W-`COUNT_W-1:0] pad;
		fdCount count;
	} fdCollision;

	// Read according to fdResultKind
	typedef union packed
	{
		fdEntry entry;
		fdCollision collision;
	} fdResult;

endpackage

//--- include/freqExt_consts.svh
// Table size is fixed here; HASH_LEN must equal 2**HASH_BITS and RESULT_W must be WORD_W+COUNT_W
`ifndef FREQEXT_CONSTS_SVH
`define FREQEXT_CONSTS_SVH

////////////////////////////////////////
// Data widths
`define WORD_W 16
`define COUNT_W 16
`define RESULT_W 32

////////////////////////////////////////
// Hash table geometry
`define HASH_BITS 4
`define HASH_LEN 16

////////////////////////////////////////
// Result addressing and run control
`define ADDR_W 32
`define ADDR_STEP 4
`define TIMER_W 32
`define NUM_BLOCK_W 10

`endif
